// ==== mg_node.f ====
+incdir+source
source/mg_pkg.sv
source/mg_beat_fifo.sv
source/mg_frame_buffer.sv
source/mg_cmd_ctrl.sv
source/mg_dev_config.sv
source/mg_node.sv
tests/mg_node_checker.sv
tests/mg_node_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, and grade the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 --top-module mg_node_tb \
  -f mg_node.f -o mg_node_sim \
  && ./obj_dir/mg_node_sim > sim.log 2>&1 \
  || echo "build or simulation returned an error"

cat sim.log 2>/dev/null
grep -q "Simulation finished: PASS" sim.log \
  && echo "result: pass" \
  || { echo "result: fail"; exit 1; }

// ==== source/mg_beat_fifo.sv ====
`timescale 1ns/1ps
`include "mg_defines.svh"

module mg_beat_fifo (
  input  logic          clk_in,
  input  logic          rst_in,
  input  logic          rx_valid,
  input  mg_pkg::data_t rx_data,
  input  mg_pkg::keep_t rx_keep,
  input  logic          rx_last,
  input  logic          beat_pop,
  output logic          beat_valid,
  output mg_pkg::data_t beat_data,
  output mg_pkg::keep_t beat_keep,
  output logic          beat_last,
  output logic          credit_return
);
  import mg_pkg::*;

  localparam int DEPTH = `MG_CREDITS;
  localparam int PTR_W = $clog2(DEPTH);

  data_t            mem_data [DEPTH];
  keep_t            mem_keep [DEPTH];
  logic             mem_last [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             pop;

  assign beat_valid = (count != '0);
  assign pop        = beat_valid && beat_pop;
  assign beat_data  = mem_data[rd_ptr];
  assign beat_keep  = mem_keep[rd_ptr];
  assign beat_last  = mem_last[rd_ptr];

  // the sender holds a credit per free slot, so every push finds room
  always_ff @(posedge clk_in) begin
    if (rx_valid) begin
      mem_data[wr_ptr] <= rx_data;
      mem_keep[wr_ptr] <= rx_keep;
      mem_last[wr_ptr] <= rx_last;
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      count         <= '0;
      credit_return <= 1'b0;
    end else begin
      // one credit back per popped beat
      credit_return <= pop;
      if (rx_valid) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({rx_valid, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // sender must not push past its credits
  a_no_overflow: assert property (@(posedge clk_in) disable iff (rst_in)
    rx_valid |-> (count != (PTR_W+1)'(DEPTH)))
    else $error("beat pushed into a full FIFO");

endmodule

// ==== source/mg_cmd_ctrl.sv ====
`timescale 1ns/1ps
`include "mg_defines.svh"

module mg_cmd_ctrl (
  input  logic             clk_in,
  input  logic             rst_in,
  input  logic             frame_valid,
  input  mg_pkg::buf_t     frame_data,
  input  mg_pkg::buf_len_t frame_len,
  input  mg_pkg::sn_t      dev_sn,
  output logic             frame_release,
  output mg_pkg::cfg_op_e  cfg_op
);
  import mg_pkg::*;

  localparam int BUF_W   = `MG_BUF_BYTES * 8;
  localparam int CMD_W   = `MG_CMD_BYTES * 8;
  localparam int LOCAL_W = `MG_LOCAL_CMD_BYTES * 8;

  localparam logic [CMD_W-1:0]   CMD_RESN   = `MG_CMD_RESN;
  localparam logic [LOCAL_W-1:0] LOCAL_SGAP = `MG_LOCAL_SGAP;

  ctrl_state_e        state;
  cfg_op_e            op_q;
  logic [CMD_W-1:0]   cmd_str;
  sn_t                rx_sn;
  logic [LOCAL_W-1:0] local_cmd;
  logic               is_resn;
  logic               is_sgap;

  // ------------------------------
  // command match
  // ------------------------------
  // first 12 bytes are either the global command or serial + local command
  assign cmd_str            = frame_data[BUF_W-1 -: CMD_W];
  assign {rx_sn, local_cmd} = cmd_str;

  assign is_resn = (cmd_str == CMD_RESN)
                && (frame_len == buf_len_t'(`MG_RESN_LEN));

  // local commands only apply to the device with this serial
  assign is_sgap = (rx_sn == dev_sn)
                && (local_cmd == LOCAL_SGAP)
                && (frame_len == buf_len_t'(`MG_SGAP_LEN));

  // ------------------------------
  // FSM
  // ------------------------------
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state <= IDLE;
      op_q  <= OP_NONE;
    end else begin
      case (state)
        IDLE: begin
          if (frame_valid) begin
            state <= DECODE;
          end
        end
        DECODE: begin
          if (is_resn) begin
            op_q <= OP_RESN;
          end else if (is_sgap) begin
            op_q <= OP_SGAP;
          end else begin
            op_q <= OP_NONE;
          end
          state <= APPLY;
        end
        APPLY: begin
          state <= IDLE;
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // write and release together while the buffer still holds the frame
  assign frame_release = (state == APPLY);
  assign cfg_op        = (state == APPLY) ? op_q : OP_NONE;

  // the decoded frame stays held and unchanged until the record write
  a_frame_held: assert property (@(posedge clk_in) disable iff (rst_in)
    (state == APPLY) |-> frame_valid && $stable(frame_data) && $stable(frame_len))
    else $error("frame dropped or changed between decode and record write");

endmodule

// ==== source/mg_defines.svh ====
`ifndef MG_DEFINES_SVH
`define MG_DEFINES_SVH

// beat and frame sizes in bytes
`define MG_DATA_BYTES 8
`define MG_BUF_BYTES 82
`define MG_CMD_BYTES 12
`define MG_NAME_BYTES 6
`define MG_SN_BYTES 8
`define MG_LOCAL_CMD_BYTES 4
`define MG_SGAP_BYTES 4

// resn record: name, serial, group addr/port, mac, ip, port
`define MG_REC_BYTES 32
`define MG_REC_OFFSET 12
`define MG_RESN_LEN 44

// sgap frame: serial, "sgap", name, 4 byte argument
`define MG_SGAP_OFFSET 18
`define MG_SGAP_LEN 22

// input FIFO depth, equal to the sender's starting credit
`define MG_CREDITS 4

`define MG_DEV_NAME "f9pcap"
`define MG_CMD_RESN "fonwin:resn:"
`define MG_LOCAL_SGAP "sgap"

`endif

// ==== source/mg_dev_config.sv ====
`timescale 1ns/1ps
`include "mg_defines.svh"

module mg_dev_config (
  input  logic              clk_in,
  input  logic              rst_in,
  input  mg_pkg::cfg_op_e   cfg_op,
  input  mg_pkg::buf_t      frame_data,
  output logic              dev_en,
  output mg_pkg::sn_t       dev_sn,
  output mg_pkg::ip_addr_t  mcgroup_addr,
  output mg_pkg::ip_port_t  mcgroup_port,
  output mg_pkg::mac_addr_t src_mac_addr,
  output mg_pkg::ip_addr_t  src_ip_addr,
  output mg_pkg::ip_port_t  src_port,
  output mg_pkg::sgap_t     local_sgap
);
  import mg_pkg::*;

  localparam int BUF_W  = `MG_BUF_BYTES * 8;
  localparam int REC_W  = `MG_REC_BYTES * 8;
  localparam int SGAP_W = `MG_SGAP_BYTES * 8;

  localparam name_t DEV_NAME = `MG_DEV_NAME;

  name_t            dev_name;
  logic [REC_W-1:0] rec_field;
  sgap_t            sgap_field;

  // record follows the 12 byte command, sgap argument follows the name
  assign rec_field  = frame_data[BUF_W-1-`MG_REC_OFFSET*8 -: REC_W];
  assign sgap_field = frame_data[BUF_W-1-`MG_SGAP_OFFSET*8 -: SGAP_W];

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      dev_en       <= 1'b0;
      dev_name     <= '0;
      dev_sn       <= '0;
      mcgroup_addr <= '0;
      mcgroup_port <= '0;
      src_mac_addr <= '0;
      src_ip_addr  <= '0;
      src_port     <= '0;
      local_sgap   <= '0;
    end else begin
      // enable tracks the stored name
      dev_en <= (dev_name == DEV_NAME);
      case (cfg_op)
        OP_RESN: begin
          {dev_name, dev_sn, mcgroup_addr, mcgroup_port,
           src_mac_addr, src_ip_addr, src_port} <= rec_field;
        end
        OP_SGAP: begin
          local_sgap <= sgap_field;
        end
        default: begin
          local_sgap <= local_sgap;
        end
      endcase
    end
  end

endmodule

// ==== source/mg_frame_buffer.sv ====
`timescale 1ns/1ps
`include "mg_defines.svh"

module mg_frame_buffer (
  input  logic             clk_in,
  input  logic             rst_in,
  input  logic             beat_valid,
  input  mg_pkg::data_t    beat_data,
  input  mg_pkg::keep_t    beat_keep,
  input  logic             beat_last,
  output logic             beat_pop,
  input  logic             frame_release,
  output logic             frame_valid,
  output mg_pkg::buf_t     frame_data,
  output mg_pkg::buf_len_t frame_len
);
  import mg_pkg::*;

  localparam int NBYTES    = `MG_DATA_BYTES;
  localparam int BUF_BYTES = `MG_BUF_BYTES;

  buf_t     buf_q;
  buf_t     buf_next;
  buf_len_t byte_cnt;
  buf_len_t lane_idx;
  logic [7:0] cnt_sum;
  keep_t    keep_inv;
  keep_t    keep_gap;
  logic     overlong;
  logic     pop;

  // hold off the FIFO while a frame waits for the controller
  assign beat_pop   = !frame_valid;
  assign pop        = beat_valid && beat_pop;
  assign cnt_sum    = {1'b0, byte_cnt} + 8'($countones(beat_keep));
  assign frame_data = buf_q;
  assign frame_len  = overlong ? buf_len_t'(BUF_BYTES + 1) : byte_cnt;

  // ------------------------------
  // byte placement
  // ------------------------------
  // lane 0 is the top byte of the beat and lands at byte_cnt
  always_comb begin
    buf_next = buf_q;
    lane_idx = byte_cnt;
    for (int i = 0; i < NBYTES; i++) begin
      lane_idx = byte_cnt + buf_len_t'(i);
      if (beat_keep[NBYTES-1-i] && (lane_idx < buf_len_t'(BUF_BYTES))) begin
        buf_next[(BUF_BYTES-1-lane_idx)*8 +: 8] = beat_data[(NBYTES-1-i)*8 +: 8];
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (frame_release) begin
      buf_q <= '0;
    end else if (pop) begin
      buf_q <= buf_next;
    end
  end

  // ------------------------------
  // count and frame state
  // ------------------------------
  always_ff @(posedge clk_in) begin
    if (rst_in || frame_release) begin
      byte_cnt    <= '0;
      overlong    <= 1'b0;
      frame_valid <= 1'b0;
    end else if (pop) begin
      // count saturates at capacity, the rest of the frame is dropped
      if (cnt_sum > 8'(BUF_BYTES)) begin
        overlong <= 1'b1;
        byte_cnt <= buf_len_t'(BUF_BYTES);
      end else begin
        byte_cnt <= cnt_sum[6:0];
      end
      if (beat_last) begin
        frame_valid <= 1'b1;
      end
    end
  end

  // keep must look like 1..10..0 so the byte count stays correct
  assign keep_inv = ~beat_keep;
  assign keep_gap = keep_inv & (keep_inv + 1'b1);

  a_keep_shape: assert property (@(posedge clk_in) disable iff (rst_in)
    pop |-> (beat_keep != '0) && (keep_gap == '0))
    else $error("keep not contiguous from the top byte");

endmodule

// ==== source/mg_node.sv ====
`timescale 1ns/1ps

module mg_node (
  input  logic              clk_in,
  input  logic              rst_in,
  input  logic              rx_valid,
  input  mg_pkg::data_t     rx_data,
  input  mg_pkg::keep_t     rx_keep,
  input  logic              rx_last,
  output logic              credit_return,
  output logic              dev_en,
  output mg_pkg::sn_t       dev_sn,
  output mg_pkg::ip_addr_t  mcgroup_addr,
  output mg_pkg::ip_port_t  mcgroup_port,
  output mg_pkg::mac_addr_t src_mac_addr,
  output mg_pkg::ip_addr_t  src_ip_addr,
  output mg_pkg::ip_port_t  src_port,
  output mg_pkg::sgap_t     local_sgap
);
  import mg_pkg::*;

  // ------------------------------
  // FIFO to buffer
  // ------------------------------
  logic  beat_valid;
  data_t beat_data;
  keep_t beat_keep;
  logic  beat_last;
  logic  beat_pop;

  // ------------------------------
  // buffer to controller and record
  // ------------------------------
  logic     frame_valid;
  buf_t     frame_data;
  buf_len_t frame_len;
  logic     frame_release;
  cfg_op_e  cfg_op;

  mg_beat_fifo fifo_i (
    .clk_in        (clk_in),
    .rst_in        (rst_in),
    .rx_valid      (rx_valid),
    .rx_data       (rx_data),
    .rx_keep       (rx_keep),
    .rx_last       (rx_last),
    .beat_pop      (beat_pop),
    .beat_valid    (beat_valid),
    .beat_data     (beat_data),
    .beat_keep     (beat_keep),
    .beat_last     (beat_last),
    .credit_return (credit_return)
  );

  mg_frame_buffer buf_i (
    .clk_in        (clk_in),
    .rst_in        (rst_in),
    .beat_valid    (beat_valid),
    .beat_data     (beat_data),
    .beat_keep     (beat_keep),
    .beat_last     (beat_last),
    .beat_pop      (beat_pop),
    .frame_release (frame_release),
    .frame_valid   (frame_valid),
    .frame_data    (frame_data),
    .frame_len     (frame_len)
  );

  // serial match for local commands uses the stored record
  mg_cmd_ctrl ctrl_i (
    .clk_in        (clk_in),
    .rst_in        (rst_in),
    .frame_valid   (frame_valid),
    .frame_data    (frame_data),
    .frame_len     (frame_len),
    .dev_sn        (dev_sn),
    .frame_release (frame_release),
    .cfg_op        (cfg_op)
  );

  mg_dev_config cfg_i (
    .clk_in       (clk_in),
    .rst_in       (rst_in),
    .cfg_op       (cfg_op),
    .frame_data   (frame_data),
    .dev_en       (dev_en),
    .dev_sn       (dev_sn),
    .mcgroup_addr (mcgroup_addr),
    .mcgroup_port (mcgroup_port),
    .src_mac_addr (src_mac_addr),
    .src_ip_addr  (src_ip_addr),
    .src_port     (src_port),
    .local_sgap   (local_sgap)
  );

endmodule

// ==== source/mg_pkg.sv ====
`include "mg_defines.svh"

package mg_pkg;

  // ------------------------------
  // payload and frame types
  // ------------------------------
  typedef logic [`MG_DATA_BYTES*8-1:0] data_t;
  typedef logic [`MG_DATA_BYTES-1:0] keep_t;

  // byte 0 of the frame sits in the top byte
  typedef logic [`MG_BUF_BYTES*8-1:0] buf_t;
  typedef logic [6:0] buf_len_t;

  // ------------------------------
  // device record fields
  // ------------------------------
  typedef logic [`MG_SN_BYTES*8-1:0] sn_t;
  typedef logic [`MG_NAME_BYTES*8-1:0] name_t;
  typedef logic [31:0] ip_addr_t;
  typedef logic [15:0] ip_port_t;
  typedef logic [47:0] mac_addr_t;
  typedef logic [`MG_SGAP_BYTES*8-1:0] sgap_t;

  // ------------------------------
  // control
  // ------------------------------
  typedef enum logic [1:0] {IDLE, DECODE, APPLY} ctrl_state_e;

  typedef enum logic [1:0] {OP_NONE, OP_RESN, OP_SGAP} cfg_op_e;

endpackage

// ==== tests/mg_node_checker.sv ====
`timescale 1ns/1ps
`include "mg_defines.svh"

module mg_node_checker (
  input  logic              clk_in,
  input  logic              rst_in,
  input  logic              rx_valid,
  input  logic              credit_return,
  input  logic              dev_en,
  input  mg_pkg::sn_t       dev_sn,
  input  mg_pkg::ip_addr_t  mcgroup_addr,
  input  mg_pkg::ip_port_t  mcgroup_port,
  input  mg_pkg::mac_addr_t src_mac_addr,
  input  mg_pkg::ip_addr_t  src_ip_addr,
  input  mg_pkg::ip_port_t  src_port,
  input  mg_pkg::sgap_t     local_sgap,
  input  logic              check_stb,
  input  logic              exp_en,
  input  logic [255:0]      exp_rec,
  input  mg_pkg::sgap_t     exp_sgap,
  output int                value_errors,
  output int                credit_errors,
  output int                credit_pulses
);
  import mg_pkg::*;

  int outstanding;

  // ------------------------------
  // expected record fields
  // ------------------------------
  sn_t       exp_sn;
  ip_addr_t  exp_gaddr;
  ip_port_t  exp_gport;
  mac_addr_t exp_mac;
  ip_addr_t  exp_ip;
  ip_port_t  exp_port;

  // name sits in the top 48 bits and is not a port of the DUT
  assign exp_sn    = exp_rec[207:144];
  assign exp_gaddr = exp_rec[143:112];
  assign exp_gport = exp_rec[111:96];
  assign exp_mac   = exp_rec[95:48];
  assign exp_ip    = exp_rec[47:16];
  assign exp_port  = exp_rec[15:0];

  task automatic compare(input string name, input logic [63:0] exp_val,
                         input logic [63:0] act_val);
    if (act_val !== exp_val) begin
      $display("[FAIL] %0t %s expected %h got %h", $time, name, exp_val, act_val);
      value_errors++;
    end
  endtask

  always @(posedge clk_in) begin
    if (!rst_in) begin
      if (rx_valid) begin
        outstanding++;
      end
      if (credit_return) begin
        credit_pulses++;
        outstanding--;
      end
      if (outstanding > `MG_CREDITS) begin
        $display("%0t: %0d beats outstanding, more than the credit limit", $time, outstanding);
        credit_errors++;
      end
      if (outstanding < 0) begin
        $display("%0t: credit returned with no beat outstanding", $time);
        credit_errors++;
        outstanding = 0;
      end
    end
    if (check_stb) begin
      if (outstanding != 0) begin
        $display("%0t: %0d credits still outstanding at check", $time, outstanding);
        credit_errors++;
      end
      compare("dev_en", 64'(exp_en), 64'(dev_en));
      compare("dev_sn", exp_sn, dev_sn);
      compare("mcgroup_addr", 64'(exp_gaddr), 64'(mcgroup_addr));
      compare("mcgroup_port", 64'(exp_gport), 64'(mcgroup_port));
      compare("src_mac_addr", 64'(exp_mac), 64'(src_mac_addr));
      compare("src_ip_addr", 64'(exp_ip), 64'(src_ip_addr));
      compare("src_port", 64'(exp_port), 64'(src_port));
      compare("local_sgap", 64'(exp_sgap), 64'(local_sgap));
    end
  end

endmodule

// ==== tests/mg_node_tb.sv ====
`timescale 1ns/1ps
`include "mg_defines.svh"

module mg_node_tb;
  import mg_pkg::*;

  localparam int ROWS      = 10;
  localparam int MAX_BYTES = 96;
  localparam int LIMIT     = 200 * ROWS + 100;

  localparam logic [95:0] CMD_OK     = `MG_CMD_RESN;
  localparam logic [95:0] CMD_BAD    = "fonwin:resx:";
  localparam logic [31:0] LOCAL_SGAP = `MG_LOCAL_SGAP;
  localparam name_t       DEV_NAME   = `MG_DEV_NAME;
  localparam sn_t         SN_A       = 64'h0123456789abcdef;
  localparam sn_t         SN_B       = 64'h1122334455667788;

  // record layout is name, serial, group addr, group port, mac, ip and port
  localparam logic [255:0] REC_A = {"f9pcap", SN_A, 32'hef010203, 16'h1f90,
                                    48'h02a1b2c3d4e5, 32'hc0a80a05, 16'h2710};
  localparam logic [255:0] REC_X = {"f9pcap", 64'h5555aaaa5555aaaa, 32'hef7f7f7f, 16'h0bad,
                                    48'h02badbadbad0, 32'h0a0b0c0d, 16'hbeef};
  localparam logic [255:0] REC_B = {"other1", SN_B, 32'hef0a0b0c, 16'h3039,
                                    48'h02fedcba9876, 32'hac100001, 16'h4e20};
  localparam logic [255:0] REC_C = {"f9pcap", 64'h8877665544332211, 32'hef000001, 16'h0fa0,
                                    48'h0211223344ff, 32'h0a000002, 16'h1388};

  logic clk_in;
  logic rst_in;
  logic rx_valid;
  data_t rx_data;
  keep_t rx_keep;
  logic rx_last;
  logic credit_return;
  logic dev_en;
  sn_t dev_sn;
  ip_addr_t mcgroup_addr;
  ip_port_t mcgroup_port;
  mac_addr_t src_mac_addr;
  ip_addr_t src_ip_addr;
  ip_port_t src_port;
  sgap_t local_sgap;

  logic check_stb;
  logic exp_en;
  logic [255:0] exp_rec;
  sgap_t exp_sgap;
  int value_errors;
  int credit_errors;
  int credit_pulses;

  // ------------------------------
  // frame table
  // ------------------------------
  logic [7:0]   row_bytes [ROWS][MAX_BYTES];
  int           row_len   [ROWS];
  bit           row_check [ROWS];
  bit           row_en    [ROWS];
  logic [255:0] row_rec   [ROWS];
  sgap_t        row_sgap  [ROWS];

  int credits;
  int beats_sent;
  int sender_errors;
  int cycles;

  mg_node mg_node_i (
    .clk_in        (clk_in),
    .rst_in        (rst_in),
    .rx_valid      (rx_valid),
    .rx_data       (rx_data),
    .rx_keep       (rx_keep),
    .rx_last       (rx_last),
    .credit_return (credit_return),
    .dev_en        (dev_en),
    .dev_sn        (dev_sn),
    .mcgroup_addr  (mcgroup_addr),
    .mcgroup_port  (mcgroup_port),
    .src_mac_addr  (src_mac_addr),
    .src_ip_addr   (src_ip_addr),
    .src_port      (src_port),
    .local_sgap    (local_sgap)
  );

  mg_node_checker check_i (
    .clk_in        (clk_in),
    .rst_in        (rst_in),
    .rx_valid      (rx_valid),
    .credit_return (credit_return),
    .dev_en        (dev_en),
    .dev_sn        (dev_sn),
    .mcgroup_addr  (mcgroup_addr),
    .mcgroup_port  (mcgroup_port),
    .src_mac_addr  (src_mac_addr),
    .src_ip_addr   (src_ip_addr),
    .src_port      (src_port),
    .local_sgap    (local_sgap),
    .check_stb     (check_stb),
    .exp_en        (exp_en),
    .exp_rec       (exp_rec),
    .exp_sgap      (exp_sgap),
    .value_errors  (value_errors),
    .credit_errors (credit_errors),
    .credit_pulses (credit_pulses)
  );

  initial begin
    clk_in = 1'b0;
  end

  always #10 clk_in = ~clk_in;

  // run limit scales with the table
  always @(posedge clk_in) begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT) begin
      $display("timeout: run stopped after %0d cycles without finishing", cycles);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // ------------------------------
  // table helpers
  // ------------------------------
  task automatic put_bytes(input int r, input int pos, input logic [255:0] val, input int n);
    for (int k = 0; k < n; k++) begin
      row_bytes[r][pos+k] = val[(n-1-k)*8 +: 8];
    end
  endtask

  task automatic fill_row(input int r);
    for (int k = 0; k < MAX_BYTES; k++) begin
      row_bytes[r][k] = 8'(k * 13 + r * 7 + 1);
    end
  endtask

  task automatic set_expect(input int r, input int len, input bit chk, input bit en,
                            input logic [255:0] rec, input sgap_t gap);
    row_len[r]   = len;
    row_check[r] = chk;
    row_en[r]    = en;
    row_rec[r]   = rec;
    row_sgap[r]  = gap;
  endtask

  task automatic add_resn(input int r, input logic [95:0] cmd, input logic [255:0] rec,
                          input int len, input bit chk, input bit en,
                          input logic [255:0] erec, input sgap_t egap);
    fill_row(r);
    put_bytes(r, 0, 256'(cmd), `MG_CMD_BYTES);
    put_bytes(r, 12, rec, `MG_REC_BYTES);
    set_expect(r, len, chk, en, erec, egap);
  endtask

  // serial, local command, name, then the 4 byte gap
  task automatic add_sgap(input int r, input sn_t sn, input sgap_t gap, input int len,
                          input bit chk, input bit en, input logic [255:0] erec,
                          input sgap_t egap);
    fill_row(r);
    put_bytes(r, 0, 256'(sn), `MG_SN_BYTES);
    put_bytes(r, 8, 256'(LOCAL_SGAP), 4);
    put_bytes(r, 12, 256'(DEV_NAME), `MG_NAME_BYTES);
    put_bytes(r, 18, 256'(gap), 4);
    set_expect(r, len, chk, en, erec, egap);
  endtask

  task automatic build_table();
    add_resn(0, CMD_OK, REC_A, 44, 1, 1'b1, REC_A, 32'h0);
    add_sgap(1, SN_A, 32'h00001234, 22, 1, 1'b1, REC_A, 32'h00001234);
    add_sgap(2, SN_A ^ 64'h1, 32'hdeadbeef, 22, 1, 1'b1, REC_A, 32'h00001234);
    add_sgap(3, SN_A, 32'h55aa55aa, 23, 1, 1'b1, REC_A, 32'h00001234);
    add_resn(4, CMD_BAD, REC_X, 44, 1, 1'b1, REC_A, 32'h00001234);
    add_resn(5, CMD_OK, REC_X, 45, 1, 1'b1, REC_A, 32'h00001234);
    add_resn(6, CMD_OK, REC_X, 90, 1, 1'b1, REC_A, 32'h00001234);
    // rows 7 and 8 go back to back so row 8 waits behind the held frame
    add_resn(7, CMD_OK, REC_B, 44, 0, 1'b0, REC_B, 32'h00001234);
    add_sgap(8, SN_B, 32'h0000abcd, 22, 1, 1'b0, REC_B, 32'h0000abcd);
    add_resn(9, CMD_OK, REC_C, 44, 1, 1'b1, REC_C, 32'h0000abcd);
  endtask

  // ------------------------------
  // sender
  // ------------------------------
  task automatic tick();
    @(posedge clk_in);
    if (credit_return) begin
      credits++;
    end
  endtask

  task automatic send_frame(input int r);
    int nbeats;
    int b;
    int idx;
    data_t d;
    keep_t k;
    nbeats = (row_len[r] + 7) / 8;
    b = 0;
    while (b < nbeats) begin
      tick();
      if (credits > 0 && ($urandom % 4) != 0) begin
        d = '0;
        k = '0;
        for (int i = 0; i < `MG_DATA_BYTES; i++) begin
          idx = b * `MG_DATA_BYTES + i;
          if (idx < row_len[r]) begin
            d[(`MG_DATA_BYTES-1-i)*8 +: 8] = row_bytes[r][idx];
            k[`MG_DATA_BYTES-1-i] = 1'b1;
          end
        end
        rx_valid <= 1'b1;
        rx_data  <= d;
        rx_keep  <= k;
        rx_last  <= (b == nbeats - 1);
        credits--;
        beats_sent++;
        b++;
      end else begin
        rx_valid <= 1'b0;
      end
    end
  endtask

  task automatic strobe(input bit en, input logic [255:0] rec, input sgap_t gap);
    tick();
    exp_en    <= en;
    exp_rec   <= rec;
    exp_sgap  <= gap;
    check_stb <= 1'b1;
    tick();
    check_stb <= 1'b0;
  endtask

  initial begin
    void'($urandom(32'h7a67d5a6));
    credits       = `MG_CREDITS;
    beats_sent    = 0;
    sender_errors = 0;
    rst_in    <= 1'b1;
    rx_valid  <= 1'b0;
    rx_data   <= '0;
    rx_keep   <= '0;
    rx_last   <= 1'b0;
    check_stb <= 1'b0;
    exp_en    <= 1'b0;
    exp_rec   <= '0;
    exp_sgap  <= '0;
    build_table();
    repeat (10) tick();
    rst_in <= 1'b0;
    repeat (5) tick();
    // idle after reset leaves the record cleared with no credits returned
    strobe(1'b0, '0, '0);
    for (int r = 0; r < ROWS; r++) begin
      send_frame(r);
      if (row_check[r]) begin
        tick();
        rx_valid <= 1'b0;
        while (credits < `MG_CREDITS) begin
          tick();
        end
        repeat (5) tick();
        strobe(row_en[r], row_rec[r], row_sgap[r]);
      end
    end
    repeat (5) tick();
    if (credit_pulses != beats_sent) begin
      $display("credit count wrong: %0d pulses for %0d beats sent", credit_pulses, beats_sent);
      sender_errors++;
    end
    $display("errors: value %0d, credit %0d, sender %0d",
             value_errors, credit_errors, sender_errors);
    if (value_errors == 0 && credit_errors == 0 && sender_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule
